// File: verilog/xcvr_mgmt_pkg.sv
package xcvr_mgmt_pkg;

  typedef logic [7:0]  mgmt_addr_t;
  typedef logic [31:0] mgmt_data_t;

  // one management access as both register blocks see it
  typedef struct packed {
    mgmt_addr_t address;
    logic       read;
    logic       write;
    mgmt_data_t writedata;
  } mgmt_req_t;

  // single-cycle requests into the reset sequencer
  typedef struct packed {
    logic reset_all;
    logic reset_tx_digital;
    logic reset_rx_digital;
  } reset_req_t;

  //////////////////////////////////////////////////
  // common register map
  //////////////////////////////////////////////////
  localparam mgmt_addr_t addr_pll_locked    = 8'h41;  // ro
  localparam mgmt_addr_t addr_pll_powerdown = 8'h42;  // rw, bit 0
  localparam mgmt_addr_t addr_reset_ctrl    = 8'h44;  // write pulses, reads 0
  localparam mgmt_addr_t addr_ready         = 8'h45;  // ro, rx_ready:tx_ready
  localparam mgmt_addr_t addr_loopback      = 8'h61;
  localparam mgmt_addr_t addr_locktoref     = 8'h62;
  localparam mgmt_addr_t addr_locktodata    = 8'h63;
  localparam mgmt_addr_t addr_lockedtodata  = 8'h64;  // ro
  localparam mgmt_addr_t addr_lockedtoref   = 8'h65;  // ro

  //////////////////////////////////////////////////
  // pcs register map
  //////////////////////////////////////////////////
  localparam mgmt_addr_t addr_tx_invpolarity = 8'h80;
  localparam mgmt_addr_t addr_rx_invpolarity = 8'h81;
  localparam mgmt_addr_t addr_rx_bitreversal = 8'h82;
  localparam mgmt_addr_t addr_syncstatus     = 8'h83;  // ro
  localparam mgmt_addr_t addr_fifo_error     = 8'h84;  // rx at bit 0, tx at bit 16

  // reset phase lengths in ns
  localparam int t_pll_powerdown_ns   = 1000;
  localparam int t_tx_digitalreset_ns = 20;
  localparam int t_rx_analogreset_ns  = 40;
  localparam int t_rx_digitalreset_ns = 4000;

endpackage

// File: verilog/csr_common.sv
module csr_common #(
  parameter int lanes = 4
) (
  input  logic                      mgmt_clk,
  input  logic                      embedded_reset,
  input  xcvr_mgmt_pkg::mgmt_req_t  req,
  output xcvr_mgmt_pkg::mgmt_data_t readdata,
  output xcvr_mgmt_pkg::reset_req_t rst_req,
  output logic                      csr_pll_powerdown,
  output logic [lanes-1:0]          loopback_serial,
  output logic [lanes-1:0]          set_locktoref,
  output logic [lanes-1:0]          set_locktodata,
  input  logic                      pll_locked,
  input  logic [lanes-1:0]          rx_is_lockedtodata,
  input  logic [lanes-1:0]          rx_is_lockedtoref,
  input  logic                      tx_ready,
  input  logic                      rx_ready
);
  import xcvr_mgmt_pkg::*;

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////
  always_ff @(posedge mgmt_clk) begin
    if (embedded_reset) begin
      rst_req           <= '0;
      csr_pll_powerdown <= 1'b0;
      loopback_serial   <= '0;
      set_locktoref     <= '0;
      set_locktodata    <= '0;
    end else begin
      rst_req <= '0;  // pulses drop after one cycle
      if (req.write) begin
        case (req.address)
          addr_pll_powerdown: csr_pll_powerdown <= req.writedata[0];
          addr_reset_ctrl: begin
            rst_req.reset_all        <= req.writedata[0];
            rst_req.reset_tx_digital <= req.writedata[1];
            rst_req.reset_rx_digital <= req.writedata[2];
          end
          addr_loopback:   loopback_serial <= req.writedata[lanes-1:0];
          addr_locktoref:  set_locktoref   <= req.writedata[lanes-1:0];
          addr_locktodata: set_locktodata  <= req.writedata[lanes-1:0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // read side, all ones off our range
  //////////////////////////////////////////////////
  always_comb begin
    readdata = '1;
    if (req.read) begin
      case (req.address)
        addr_pll_locked:    readdata = mgmt_data_t'(pll_locked);
        addr_pll_powerdown: readdata = mgmt_data_t'(csr_pll_powerdown);
        addr_reset_ctrl:    readdata = '0;
        addr_ready:         readdata = mgmt_data_t'({rx_ready, tx_ready});
        addr_loopback:      readdata = mgmt_data_t'(loopback_serial);
        addr_locktoref:     readdata = mgmt_data_t'(set_locktoref);
        addr_locktodata:    readdata = mgmt_data_t'(set_locktodata);
        addr_lockedtodata:  readdata = mgmt_data_t'(rx_is_lockedtodata);
        addr_lockedtoref:   readdata = mgmt_data_t'(rx_is_lockedtoref);
        default: ;
      endcase
    end
  end

  // sequencer counts each request once
  a_rst_req_pulse: assert property (
    @(posedge mgmt_clk) disable iff (embedded_reset)
    (rst_req != '0) |=> (rst_req & $past(rst_req)) == '0
  ) else $error("reset request held longer than one cycle");

endmodule

// File: verilog/csr_pcs.sv
module csr_pcs #(
  parameter int lanes = 4
) (
  input  logic                      mgmt_clk,
  input  logic                      embedded_reset,
  input  xcvr_mgmt_pkg::mgmt_req_t  req,
  output xcvr_mgmt_pkg::mgmt_data_t readdata,
  output logic [lanes-1:0]          tx_invpolarity,
  output logic [lanes-1:0]          rx_invpolarity,
  output logic [lanes-1:0]          rx_bitreversalenable,
  input  logic [lanes-1:0]          rx_syncstatus,
  input  logic [lanes-1:0]          rx_fifo_error,
  input  logic [lanes-1:0]          tx_fifo_error
);
  import xcvr_mgmt_pkg::*;

  logic [lanes-1:0] sync_meta;
  logic [lanes-1:0] sync_q;
  logic [lanes-1:0] rx_err_sticky;
  logic [lanes-1:0] tx_err_sticky;
  logic             fifo_clr;
  logic [lanes-1:0] rx_clr;
  logic [lanes-1:0] tx_clr;

  // write-one-to-clear masks
  assign fifo_clr = req.write && (req.address == addr_fifo_error);
  assign rx_clr   = fifo_clr ? req.writedata[lanes-1:0] : '0;
  assign tx_clr   = fifo_clr ? req.writedata[16 +: lanes] : '0;

  always_ff @(posedge mgmt_clk) begin
    if (embedded_reset) begin
      tx_invpolarity       <= '0;
      rx_invpolarity       <= '0;
      rx_bitreversalenable <= '0;
      rx_err_sticky        <= '0;
      tx_err_sticky        <= '0;
    end else begin
      if (req.write) begin
        case (req.address)
          addr_tx_invpolarity: tx_invpolarity       <= req.writedata[lanes-1:0];
          addr_rx_invpolarity: rx_invpolarity       <= req.writedata[lanes-1:0];
          addr_rx_bitreversal: rx_bitreversalenable <= req.writedata[lanes-1:0];
          default: ;
        endcase
      end
      // a new error wins over a clear in the same cycle
      rx_err_sticky <= rx_fifo_error | (rx_err_sticky & ~rx_clr);
      tx_err_sticky <= tx_fifo_error | (tx_err_sticky & ~tx_clr);
    end
  end

  // two-flop sync for lane status
  always_ff @(posedge mgmt_clk) begin
    sync_meta <= rx_syncstatus;
    sync_q    <= sync_meta;
  end

  always_comb begin
    readdata = '1;
    if (req.read) begin
      case (req.address)
        addr_tx_invpolarity: readdata = mgmt_data_t'(tx_invpolarity);
        addr_rx_invpolarity: readdata = mgmt_data_t'(rx_invpolarity);
        addr_rx_bitreversal: readdata = mgmt_data_t'(rx_bitreversalenable);
        addr_syncstatus:     readdata = mgmt_data_t'(sync_q);
        addr_fifo_error: begin
          readdata               = '0;
          readdata[lanes-1:0]    = rx_err_sticky;
          readdata[16 +: lanes]  = tx_err_sticky;
        end
        default: ;
      endcase
    end
  end

  a_sticky_hold: assert property (
    @(posedge mgmt_clk) disable iff (embedded_reset)
    !fifo_clr |=> ($past({tx_err_sticky, rx_err_sticky}) &
                   ~{tx_err_sticky, rx_err_sticky}) == '0
  ) else $error("sticky fifo error cleared without a write");

endmodule

// File: verilog/mgmt_bus_merge.sv
module mgmt_bus_merge #(
  parameter int lanes = 4
) (
  input  logic                      mgmt_clk,
  input  logic                      embedded_reset,
  input  logic                      mgmt_read,
  input  xcvr_mgmt_pkg::mgmt_data_t common_readdata,
  input  xcvr_mgmt_pkg::mgmt_data_t pcs_readdata,
  output xcvr_mgmt_pkg::mgmt_data_t mgmt_readdata,
  output logic                      mgmt_waitrequest
);

  logic read_ack;  // high in the second cycle of a read

  // lane fields of the fifo error word sit 16 bits apart
  if (lanes < 1 || lanes > 16) begin : g_lanes_check
    $error("lanes must be within 1 to 16");
  end

  assign mgmt_waitrequest = mgmt_read & ~read_ack;

  always_ff @(posedge mgmt_clk) begin
    if (embedded_reset) begin
      read_ack <= 1'b0;
    end else begin
      read_ack <= mgmt_read & ~read_ack;
    end
  end

  // blocks return all ones when not addressed, so AND picks the hit
  always_ff @(posedge mgmt_clk) begin
    if (mgmt_waitrequest) begin
      mgmt_readdata <= common_readdata & pcs_readdata;
    end
  end

  a_disjoint_decode: assert property (
    @(posedge mgmt_clk) disable iff (embedded_reset)
    mgmt_read |-> (&common_readdata) || (&pcs_readdata)
  ) else $error("both register blocks decoded address");

endmodule

// File: verilog/xcvr_reset_seq.sv
module xcvr_reset_seq #(
  parameter int lanes   = 4,
  parameter int clk_mhz = 125
) (
  input  logic                      mgmt_clk,
  input  logic                      embedded_reset,
  input  xcvr_mgmt_pkg::reset_req_t rst_req,
  input  logic                      csr_pll_powerdown,
  input  logic                      pll_locked,
  input  logic [lanes-1:0]          rx_manual,
  input  logic [lanes-1:0]          rx_is_lockedtodata,
  output logic                      pll_powerdown,
  output logic                      tx_analogreset,
  output logic [lanes-1:0]          tx_digitalreset,
  output logic [lanes-1:0]          rx_analogreset,
  output logic [lanes-1:0]          rx_digitalreset,
  output logic                      tx_ready,
  output logic                      rx_ready
);
  import xcvr_mgmt_pkg::*;

  // ceil(ns * mhz / 1000), at least one cycle
  function automatic int phase_cycles(int ns);
    int c;
    c = (ns * clk_mhz + 999) / 1000;
    return (c < 1) ? 1 : c;
  endfunction

  localparam int pd_cycles  = phase_cycles(t_pll_powerdown_ns);
  localparam int txd_cycles = phase_cycles(t_tx_digitalreset_ns);
  localparam int ana_cycles = phase_cycles(t_rx_analogreset_ns);
  localparam int rxd_cycles = phase_cycles(t_rx_digitalreset_ns);
  localparam int cnt_w      = $clog2(rxd_cycles + 1);  // longest phase

  localparam logic [1:0] tx_s_pd   = 2'd0;
  localparam logic [1:0] tx_s_lock = 2'd1;
  localparam logic [1:0] tx_s_rel  = 2'd2;
  localparam logic [1:0] tx_s_up   = 2'd3;

  localparam logic [2:0] rx_s_pd   = 3'd0;
  localparam logic [2:0] rx_s_ana  = 3'd1;
  localparam logic [2:0] rx_s_lock = 3'd2;
  localparam logic [2:0] rx_s_rel  = 3'd3;
  localparam logic [2:0] rx_s_up   = 3'd4;

  logic [1:0]       tx_state;
  logic [2:0]       rx_state;
  logic [cnt_w-1:0] tx_cnt;
  logic [cnt_w-1:0] rx_cnt;
  logic             pll_ok;
  logic             rx_ok;

  assign pll_ok = pll_locked & ~csr_pll_powerdown;
  assign rx_ok  = &(rx_is_lockedtodata | rx_manual);  // manual lanes count as locked

  //////////////////////////////////////////////////
  // tx side: power-down, then wait on pll lock
  //////////////////////////////////////////////////
  always_ff @(posedge mgmt_clk) begin
    if (embedded_reset || rst_req.reset_all) begin
      tx_state <= tx_s_pd;
      tx_cnt   <= cnt_w'(pd_cycles - 1);
    end else if (rst_req.reset_tx_digital && tx_state != tx_s_pd) begin
      tx_state <= tx_s_lock;
      tx_cnt   <= cnt_w'(txd_cycles - 1);
    end else begin
      case (tx_state)
        tx_s_pd: begin
          if (tx_cnt == '0) begin
            tx_state <= tx_s_lock;
            tx_cnt   <= cnt_w'(txd_cycles - 1);
          end else begin
            tx_cnt <= tx_cnt - 1'b1;
          end
        end
        tx_s_lock: begin
          if (!pll_ok) begin
            tx_cnt <= cnt_w'(txd_cycles - 1);  // lock must be continuous
          end else if (tx_cnt == '0) begin
            tx_state <= tx_s_rel;
          end else begin
            tx_cnt <= tx_cnt - 1'b1;
          end
        end
        default: begin
          if (!pll_ok) begin
            tx_state <= tx_s_lock;
            tx_cnt   <= cnt_w'(txd_cycles - 1);
          end else if (tx_state == tx_s_rel) begin
            tx_state <= tx_s_up;
          end
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // rx side: analog, then cdr lock or manual
  //////////////////////////////////////////////////
  always_ff @(posedge mgmt_clk) begin
    if (embedded_reset || rst_req.reset_all) begin
      rx_state <= rx_s_pd;
      rx_cnt   <= '0;
    end else if (rst_req.reset_rx_digital && rx_state >= rx_s_lock) begin
      rx_state <= rx_s_lock;
      rx_cnt   <= cnt_w'(rxd_cycles - 1);
    end else begin
      case (rx_state)
        rx_s_pd: begin
          if (!pll_powerdown) begin
            rx_state <= rx_s_ana;
            rx_cnt   <= cnt_w'(ana_cycles - 1);
          end
        end
        rx_s_ana: begin
          if (pll_powerdown) begin
            rx_state <= rx_s_pd;
          end else if (rx_cnt == '0) begin
            rx_state <= rx_s_lock;
            rx_cnt   <= cnt_w'(rxd_cycles - 1);
          end else begin
            rx_cnt <= rx_cnt - 1'b1;
          end
        end
        rx_s_lock: begin
          if (!rx_ok) begin
            rx_cnt <= cnt_w'(rxd_cycles - 1);
          end else if (rx_cnt == '0) begin
            rx_state <= rx_s_rel;
          end else begin
            rx_cnt <= rx_cnt - 1'b1;
          end
        end
        default: begin
          if (!rx_ok) begin
            rx_state <= rx_s_lock;
            rx_cnt   <= cnt_w'(rxd_cycles - 1);
          end else if (rx_state == rx_s_rel) begin
            rx_state <= rx_s_up;
          end
        end
      endcase
    end
  end

  assign pll_powerdown   = (tx_state == tx_s_pd) | csr_pll_powerdown;
  assign tx_analogreset  = pll_powerdown;
  assign tx_digitalreset = {lanes{tx_state < tx_s_rel}};
  assign tx_ready        = (tx_state == tx_s_up) & ~csr_pll_powerdown;
  assign rx_analogreset  = {lanes{rx_state < rx_s_lock}};
  assign rx_digitalreset = {lanes{rx_state < rx_s_rel}};
  assign rx_ready        = (rx_state == rx_s_up);

  // the fsm must have left up one cycle into power-down
  a_tx_ready_pd: assert property (
    @(posedge mgmt_clk) disable iff (embedded_reset)
    pll_powerdown |-> !tx_ready ##1 (tx_state != tx_s_up)
  ) else $error("tx_ready high during pll power-down");

endmodule

// File: verilog/xcvr_phy_ctrl_top.sv
module xcvr_phy_ctrl_top #(
  parameter int lanes   = 4,
  parameter int clk_mhz = 125
) (
  input  logic                       mgmt_clk,
  input  logic                       embedded_reset,
  // management port
  input  xcvr_mgmt_pkg::mgmt_addr_t  mgmt_address,
  input  logic                       mgmt_read,
  input  logic                       mgmt_write,
  input  xcvr_mgmt_pkg::mgmt_data_t  mgmt_writedata,
  output xcvr_mgmt_pkg::mgmt_data_t  mgmt_readdata,
  output logic                       mgmt_waitrequest,
  // resets and ready
  output logic                       pll_powerdown,
  output logic                       tx_analogreset,
  output logic [lanes-1:0]           tx_digitalreset,
  output logic [lanes-1:0]           rx_analogreset,
  output logic [lanes-1:0]           rx_digitalreset,
  output logic                       tx_ready,
  output logic                       rx_ready,
  // lane controls
  output logic [lanes-1:0]           loopback_serial,
  output logic [lanes-1:0]           set_locktoref,
  output logic [lanes-1:0]           set_locktodata,
  output logic [lanes-1:0]           tx_invpolarity,
  output logic [lanes-1:0]           rx_invpolarity,
  output logic [lanes-1:0]           rx_bitreversalenable,
  // transceiver status
  input  logic                       pll_locked,
  input  logic [lanes-1:0]           rx_is_lockedtodata,
  input  logic [lanes-1:0]           rx_is_lockedtoref,
  input  logic [lanes-1:0]           rx_syncstatus,
  input  logic [lanes-1:0]           rx_fifo_error,
  input  logic [lanes-1:0]           tx_fifo_error
);
  import xcvr_mgmt_pkg::*;

  mgmt_req_t  req;
  reset_req_t rst_req;
  mgmt_data_t common_readdata;
  mgmt_data_t pcs_readdata;
  logic       csr_pll_powerdown;

  assign req = '{address: mgmt_address, read: mgmt_read, write: mgmt_write,
                 writedata: mgmt_writedata};

  csr_common #(.lanes(lanes)) u_csr_common (
    .mgmt_clk           (mgmt_clk),
    .embedded_reset     (embedded_reset),
    .req                (req),
    .readdata           (common_readdata),
    .rst_req            (rst_req),
    .csr_pll_powerdown  (csr_pll_powerdown),
    .loopback_serial    (loopback_serial),
    .set_locktoref      (set_locktoref),
    .set_locktodata     (set_locktodata),
    .pll_locked         (pll_locked),
    .rx_is_lockedtodata (rx_is_lockedtodata),
    .rx_is_lockedtoref  (rx_is_lockedtoref),
    .tx_ready           (tx_ready),
    .rx_ready           (rx_ready)
  );

  csr_pcs #(.lanes(lanes)) u_csr_pcs (
    .mgmt_clk             (mgmt_clk),
    .embedded_reset       (embedded_reset),
    .req                  (req),
    .readdata             (pcs_readdata),
    .tx_invpolarity       (tx_invpolarity),
    .rx_invpolarity       (rx_invpolarity),
    .rx_bitreversalenable (rx_bitreversalenable),
    .rx_syncstatus        (rx_syncstatus),
    .rx_fifo_error        (rx_fifo_error),
    .tx_fifo_error        (tx_fifo_error)
  );

  mgmt_bus_merge #(.lanes(lanes)) u_bus_merge (
    .mgmt_clk         (mgmt_clk),
    .embedded_reset   (embedded_reset),
    .mgmt_read        (mgmt_read),
    .common_readdata  (common_readdata),
    .pcs_readdata     (pcs_readdata),
    .mgmt_readdata    (mgmt_readdata),
    .mgmt_waitrequest (mgmt_waitrequest)
  );

  // any lock override puts that lane in manual rx mode
  xcvr_reset_seq #(.lanes(lanes), .clk_mhz(clk_mhz)) u_reset_seq (
    .mgmt_clk           (mgmt_clk),
    .embedded_reset     (embedded_reset),
    .rst_req            (rst_req),
    .csr_pll_powerdown  (csr_pll_powerdown),
    .pll_locked         (pll_locked),
    .rx_manual          (set_locktoref | set_locktodata),
    .rx_is_lockedtodata (rx_is_lockedtodata),
    .pll_powerdown      (pll_powerdown),
    .tx_analogreset     (tx_analogreset),
    .tx_digitalreset    (tx_digitalreset),
    .rx_analogreset     (rx_analogreset),
    .rx_digitalreset    (rx_digitalreset),
    .tx_ready           (tx_ready),
    .rx_ready           (rx_ready)
  );

endmodule

// File: tests/xcvr_status_model.sv
module xcvr_status_model #(
  parameter int lanes = 4
) (
  input  logic                 mgmt_clk,
  input  logic                 pll_powerdown,
  input  logic [lanes-1:0]     rx_analogreset,
  input  logic                 hold_lock,
  input  logic                 noise_en,
  input  logic [2*lanes-1:0]   err_inject,  // tx lanes on top
  output logic                 pll_locked,
  output logic [lanes-1:0]     rx_is_lockedtodata,
  output logic [lanes-1:0]     rx_is_lockedtoref,
  output logic [lanes-1:0]     rx_syncstatus,
  output logic [lanes-1:0]     rx_fifo_error,
  output logic [lanes-1:0]     tx_fifo_error
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] lcg_state;
  int          pll_cnt;
  int          lane_cnt[lanes];
  int          lane_delay[lanes];

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  initial begin
    lcg_state = 32'd34976;
    pll_cnt = 0;
    pll_locked = 1'b0;
    rx_is_lockedtodata = '0;
    rx_is_lockedtoref = '0;
    rx_syncstatus = '0;
    rx_fifo_error = '0;
    tx_fifo_error = '0;
    for (int i = 0; i < lanes; i++) begin
      lane_cnt[i] = 0;
      lane_delay[i] = 10 + int'(lcg_next() >> 16) % 32;  // cdr lock time per lane
    end
  end

  always @(posedge mgmt_clk) begin
    logic [31:0] r_sync;
    logic [31:0] r_err;
    if (pll_powerdown) begin
      pll_cnt <= 0;
      pll_locked <= 1'b0;
    end else if (pll_cnt < 20) begin
      pll_cnt <= pll_cnt + 1;
    end else begin
      pll_locked <= 1'b1;
    end
    for (int i = 0; i < lanes; i++) begin
      if (rx_analogreset[i] || hold_lock) begin
        lane_cnt[i] <= 0;
        rx_is_lockedtodata[i] <= 1'b0;
      end else if (lane_cnt[i] < lane_delay[i]) begin
        lane_cnt[i] <= lane_cnt[i] + 1;
      end else begin
        rx_is_lockedtodata[i] <= 1'b1;
      end
    end
    rx_is_lockedtoref <= {lanes{pll_locked}};
    rx_fifo_error <= err_inject[lanes-1:0];
    tx_fifo_error <= err_inject[2*lanes-1:lanes];
    if (noise_en) begin
      r_sync = lcg_next();
      r_err  = lcg_next();
      rx_syncstatus <= lanes'(r_sync >> 8);
      if (r_err[31:28] == 4'h0) begin  // rare error bursts
        rx_fifo_error <= lanes'(r_err >> 8) | err_inject[lanes-1:0];
        tx_fifo_error <= lanes'(r_err >> 20) | err_inject[2*lanes-1:lanes];
      end
    end
  end

endmodule

// File: tests/tb_xcvr_phy_ctrl.sv
module tb_xcvr_phy_ctrl;
  timeunit 1ns;
  timeprecision 1ps;
  import xcvr_mgmt_pkg::*;

  localparam int lanes = 4;

  logic mgmt_clk, embedded_reset, mgmt_read, mgmt_write, mgmt_waitrequest;
  mgmt_addr_t mgmt_address;
  mgmt_data_t mgmt_writedata, mgmt_readdata;
  logic pll_powerdown, tx_analogreset, tx_ready, rx_ready, pll_locked;
  logic [lanes-1:0] tx_digitalreset, rx_analogreset, rx_digitalreset;
  logic [lanes-1:0] loopback_serial, set_locktoref, set_locktodata;
  logic [lanes-1:0] tx_invpolarity, rx_invpolarity, rx_bitreversalenable;
  logic [lanes-1:0] rx_is_lockedtodata, rx_is_lockedtoref, rx_syncstatus;
  logic [lanes-1:0] rx_fifo_error, tx_fifo_error;
  logic hold_lock, noise_en;
  logic [2*lanes-1:0] err_inject;

  int errors, mark, tests_run, tests_failed;
  logic [31:0] lcg_state;
  mgmt_data_t rd, val;
  mgmt_addr_t rw_addr[6] = '{addr_loopback, addr_locktoref, addr_locktodata,
                             addr_tx_invpolarity, addr_rx_invpolarity, addr_rx_bitreversal};

  xcvr_phy_ctrl_top #(.lanes(lanes), .clk_mhz(125)) u_dut (.*);

  xcvr_status_model #(.lanes(lanes)) u_model (.*);

  initial begin
    mgmt_clk = 1'b0;
    forever #4 mgmt_clk = ~mgmt_clk;
  end

  ////////////////////////////////////////////////////
  // protocol and sequence checks
  ////////////////////////////////////////////////////
  a_tx_needs_lock: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    tx_ready |-> pll_locked)
  else begin
    $display("tx_ready was high while the pll was not locked");
    errors++;
  end
  a_tx_first: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    $rose(rx_ready) |-> tx_ready)
  else begin
    $display("rx_ready rose before tx_ready");
    errors++;
  end
  a_read_wait: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    $rose(mgmt_read) |-> mgmt_waitrequest ##1 !mgmt_waitrequest)
  else begin
    $display("read did not see exactly one wait cycle");
    errors++;
  end
  a_write_nowait: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    mgmt_write |-> !mgmt_waitrequest)
  else begin
    $display("waitrequest was raised on a write");
    errors++;
  end
  a_rx_lock: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    $rose(rx_ready) |-> $past(&(rx_is_lockedtodata | set_locktoref | set_locktodata)))
  else begin
    $display("rx_ready rose with a lane neither locked nor manual");
    errors++;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic mgmt_data_t port_of(mgmt_addr_t addr);
    case (addr)
      addr_loopback:       return mgmt_data_t'(loopback_serial);
      addr_locktoref:      return mgmt_data_t'(set_locktoref);
      addr_locktodata:     return mgmt_data_t'(set_locktodata);
      addr_tx_invpolarity: return mgmt_data_t'(tx_invpolarity);
      addr_rx_invpolarity: return mgmt_data_t'(rx_invpolarity);
      default:             return mgmt_data_t'(rx_bitreversalenable);
    endcase
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic mgmt_wr(input mgmt_addr_t addr, input mgmt_data_t data);
    @(posedge mgmt_clk);
    mgmt_address <= addr;
    mgmt_writedata <= data;
    mgmt_write <= 1'b1;
    @(posedge mgmt_clk);
    mgmt_write <= 1'b0;
  endtask

  task automatic mgmt_rd(input mgmt_addr_t addr, output mgmt_data_t data);
    int n;
    n = 0;
    @(posedge mgmt_clk);
    mgmt_address <= addr;
    mgmt_read <= 1'b1;
    do begin
      @(negedge mgmt_clk);
      n++;
    end while (mgmt_waitrequest && n < 10);
    if (mgmt_waitrequest) begin
      $display("read of address %h never completed", addr);
      errors++;
    end
    data = mgmt_readdata;
    @(posedge mgmt_clk);
    mgmt_read <= 1'b0;
  endtask

  // sel 0 tx_ready, 1 rx_ready, 2 pll_powerdown
  task automatic wait_level(input int sel, input logic level, input int limit, input string what);
    int n;
    logic v;
    n = 0;
    do begin
      @(negedge mgmt_clk);
      v = (sel == 0) ? tx_ready : (sel == 1) ? rx_ready : pll_powerdown;
      n++;
    end while (v !== level && n < limit);
    if (v !== level) begin
      $display("timed out waiting for %s", what);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - mark);
    end
    mark = errors;
  endtask

  initial begin
    errors = 0;
    mark = 0;
    tests_run = 0;
    tests_failed = 0;
    lcg_state = 32'd34976;
    embedded_reset = 1'b1;
    mgmt_address = '0;
    mgmt_read = 1'b0;
    mgmt_write = 1'b0;
    mgmt_writedata = '0;
    hold_lock = 1'b0;
    noise_en = 1'b1;
    err_inject = '0;

    // reset state and first bring-up
    repeat (7) @(posedge mgmt_clk);
    @(negedge mgmt_clk);
    check_eq("pll_powerdown", pll_powerdown, 1);
    check_eq("tx_analogreset", tx_analogreset, 1);
    check_eq("tx_digitalreset", tx_digitalreset, 4'hf);
    check_eq("rx_analogreset", rx_analogreset, 4'hf);
    check_eq("rx_digitalreset", rx_digitalreset, 4'hf);
    check_eq("ready", {rx_ready, tx_ready}, 0);
    @(posedge mgmt_clk);
    embedded_reset <= 1'b0;
    wait_level(0, 1'b1, 400, "tx_ready after reset");
    check_eq("tx_digitalreset", tx_digitalreset, 0);
    wait_level(1, 1'b1, 1200, "rx_ready after reset");
    check_eq("rx_analogreset", rx_analogreset, 0);
    finish_test("reset sequence");

    for (int i = 0; i < 6; i++) begin
      val = lcg_next() & 32'hf;
      mgmt_wr(rw_addr[i], val);
      mgmt_rd(rw_addr[i], rd);
      check_eq($sformatf("readback %h", rw_addr[i]), rd, val);
      check_eq($sformatf("port of %h", rw_addr[i]), port_of(rw_addr[i]), val);
      mgmt_wr(rw_addr[i], 0);
    end
    mgmt_wr(addr_pll_powerdown, 1);
    mgmt_rd(addr_pll_powerdown, rd);
    check_eq("readback pll_powerdown", rd, 1);
    check_eq("pll_powerdown", pll_powerdown, 1);
    check_eq("tx_analogreset", tx_analogreset, 1);
    mgmt_wr(addr_pll_powerdown, 0);
    mgmt_rd(addr_pll_powerdown, rd);
    check_eq("readback pll_powerdown", rd, 0);
    wait_level(0, 1'b1, 400, "tx_ready after power-down release");
    check_eq("tx_analogreset", tx_analogreset, 0);
    mgmt_rd(8'h10, rd);
    check_eq("undecoded 10", rd, 32'hffff_ffff);
    mgmt_rd(8'h90, rd);
    check_eq("undecoded 90", rd, 32'hffff_ffff);
    finish_test("read/write registers");

    noise_en <= 1'b0;  // freeze sync status
    repeat (3) @(posedge mgmt_clk);
    mgmt_rd(addr_syncstatus, rd);
    check_eq("syncstatus", rd, mgmt_data_t'(rx_syncstatus));
    mgmt_rd(addr_ready, rd);
    check_eq("ready", rd, 32'h0000_0003);  // both sides up
    mgmt_rd(addr_lockedtodata, rd);
    check_eq("lockedtodata", rd, mgmt_data_t'(rx_is_lockedtodata));
    mgmt_rd(addr_pll_locked, rd);
    check_eq("pll_locked", rd, mgmt_data_t'(pll_locked));
    finish_test("status reads");

    mgmt_wr(addr_fifo_error, 32'hffff_ffff);
    mgmt_rd(addr_fifo_error, rd);
    check_eq("fifo_error cleared", rd, 0);
    @(posedge mgmt_clk);
    err_inject <= 8'b0100_0010;  // tx lane 2, rx lane 1
    @(posedge mgmt_clk);
    err_inject <= '0;
    repeat (3) @(posedge mgmt_clk);
    mgmt_rd(addr_fifo_error, rd);
    check_eq("fifo_error set", rd, 32'h0004_0002);
    repeat (10) @(posedge mgmt_clk);
    mgmt_rd(addr_fifo_error, rd);
    check_eq("fifo_error held", rd, 32'h0004_0002);
    mgmt_wr(addr_fifo_error, 32'h0000_0002);
    mgmt_rd(addr_fifo_error, rd);
    check_eq("fifo_error rx clear", rd, 32'h0004_0000);
    mgmt_wr(addr_fifo_error, 32'h0004_0000);
    mgmt_rd(addr_fifo_error, rd);
    check_eq("fifo_error tx clear", rd, 0);
    finish_test("sticky fifo errors");

    mgmt_wr(addr_reset_ctrl, 32'h4);
    wait_level(1, 1'b0, 8, "rx_ready to drop on rx digital reset");
    check_eq("rx_digitalreset", rx_digitalreset, 4'hf);
    wait_level(1, 1'b1, 1000, "rx_ready after rx digital reset");
    check_eq("rx_digitalreset", rx_digitalreset, 0);
    mgmt_wr(addr_reset_ctrl, 32'h1);
    wait_level(2, 1'b1, 8, "pll_powerdown on reset all");
    check_eq("ready", {rx_ready, tx_ready}, 0);
    check_eq("rx_digitalreset", rx_digitalreset, 4'hf);
    wait_level(0, 1'b1, 400, "tx_ready after reset all");
    wait_level(1, 1'b1, 1200, "rx_ready after reset all");
    finish_test("reset requests");

    @(posedge mgmt_clk);
    hold_lock <= 1'b1;
    mgmt_wr(addr_reset_ctrl, 32'h4);
    wait_level(1, 1'b0, 8, "rx_ready to drop with lock held");
    for (int i = 0; i < 600; i++) begin
      @(negedge mgmt_clk);
      assert (!rx_ready) else begin
        $display("rx_ready rose while lanes were unlocked");
        errors++;
      end
    end
    mgmt_wr(addr_locktoref, 32'hffff_ffff);
    wait_level(1, 1'b1, 1000, "rx_ready in manual mode");
    hold_lock <= 1'b0;
    repeat (60) @(posedge mgmt_clk);
    mgmt_wr(addr_locktoref, 0);
    finish_test("manual rx mode");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
verilog/xcvr_mgmt_pkg.sv
verilog/csr_common.sv
verilog/csr_pcs.sv
verilog/mgmt_bus_merge.sv
verilog/xcvr_reset_seq.sv
verilog/xcvr_phy_ctrl_top.sv
tests/xcvr_status_model.sv
tests/tb_xcvr_phy_ctrl.sv

// File: Makefile
# Verilator build and run for the transceiver management testbench

VERILATOR ?= verilator
TOP       ?= tb_xcvr_phy_ctrl
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "Simulation PASSED" $(LOG) || (echo "run did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
